/* design/rhBusPkg.sv */
/*
 * RH11 device bus package
 * Types for the KS-10 style device bus as seen by the RH11 slice.
 * One bus cycle carries a register select, a read or write strobe
 * and a full 36-bit word. The reply is an ack pulse plus data.
 */
package rhBusPkg;

   ////////////////////////////////////////////////////////////
   // Bus word widths
   ////////////////////////////////////////////////////////////

   typedef logic [35:0] devDataT;           // Full KS-10 data word
   typedef logic [1:0]  devAddrT;           // Controller register select

   // Register selects decoded by the controller
   localparam devAddrT addrCs1 = 2'd0;      // Control and status 1
   localparam devAddrT addrCs2 = 2'd1;      // Control and status 2
   localparam devAddrT addrDb  = 2'd2;      // Data buffer

   ////////////////////////////////////////////////////////////
   // Bus cycle and reply
   ////////////////////////////////////////////////////////////

   // One cycle as driven by the processor side
   typedef struct packed {
      devAddrT addr;                        // Register select
      logic    read;                        // Read strobe, single cycle
      logic    write;                       // Write strobe, single cycle
      devDataT data;                        // Write data
   } devCycleT;

   // Controller answer, one cycle wide
   typedef struct packed {
      logic    ack;                         // Operation done
      devDataT data;                        // Read data, zero on writes
   } devReplyT;

endpackage

/* design/rhControlStatus.sv */
/*
 * RH11 control and status
 * Holds the CS1 function code, derives the buffer clear from GO,
 * TRE, CLR and device reset, and keeps the data late latch.
 */
module rhControlStatus (
   input  logic                clk,
   input  logic                rst,
   input  logic                devReset,
   input  rhRegPkg::regStrobeT strobes,
   input  logic                dltEvent,
   output logic                bufClear,
   output logic                dlt,
   output rhRegPkg::regWordT   cs1Word
);

   import rhRegPkg::*;

   logic devResetDly;                       // Previous devReset level
   logic resetEdge;                         // First cycle of device reset
   logic goWrite;
   logic treWrite;
   logic clrWrite;
   logic dltClear;

   ////////////////////////////////////////////////////////////
   // Clear sources
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         devResetDly <= 1'b0;
      else
         devResetDly <= devReset;
   end

   assign resetEdge = devReset & ~devResetDly; // One pulse per reset

   assign goWrite  = strobes.cs1Write & strobes.data[cs1Go];
   assign treWrite = strobes.cs1Write & strobes.data[cs1Tre];
   assign clrWrite = strobes.cs2Write & strobes.data[cs2Clr];

   // GO empties the buffer but leaves DLT alone
   assign bufClear = goWrite | treWrite | clrWrite | resetEdge;
   assign dltClear = treWrite | clrWrite | resetEdge;

   ////////////////////////////////////////////////////////////
   // CS1 function register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         cs1Word <= '0;
      else if (strobes.cs1Write)
         cs1Word <= strobes.data & cs1Func; // GO and TRE never stored
   end

   ////////////////////////////////////////////////////////////
   // Data late latch
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         dlt <= 1'b0;
      else if (dltClear)                    // Clear first
         dlt <= 1'b0;
      else if (dltEvent)
         dlt <= 1'b1;
   end

endmodule

/* design/rhController.sv */
/*
 * RH11 controller slice, top level
 * Decode, register and buffer update, then read return, on a
 * single-strobe device bus with a one-cycle acknowledge.
 */
module rhController #(
   parameter int bufDepth = 66              // Data buffer words
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               devReset,
   input  rhBusPkg::devCycleT devIn,
   output rhBusPkg::devReplyT devOut
);

   import rhRegPkg::*;

   regStrobeT strobes;                      // Stage one pulses
   regWordT   cs1Word;
   regWordT   dbWord;
   bufStatusT bufRaw;                       // ir and outRdy from the buffer
   bufStatusT bufStatus;                    // With DLT merged in
   logic      bufClear;
   logic      dlt;
   logic      dltEvent;

   rhRegDecode rhRegDecode_i (
      .clk     (clk),
      .rst     (rst),
      .devIn   (devIn),
      .strobes (strobes)
   );

   rhControlStatus rhControlStatus_i (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .strobes  (strobes),
      .dltEvent (dltEvent),
      .bufClear (bufClear),
      .dlt      (dlt),
      .cs1Word  (cs1Word)
   );

   rhDataBuffer #(
      .bufDepth (bufDepth)
   ) rhDataBuffer_i (
      .clk      (clk),
      .rst      (rst),
      .bufClear (bufClear),
      .dbWrite  (strobes.dbWrite),
      .dbRead   (strobes.dbRead),
      .dbData   (strobes.data),
      .dbWord   (dbWord),
      .status   (bufRaw),
      .dltEvent (dltEvent)
   );

   assign bufStatus = '{ir: bufRaw.ir, outRdy: bufRaw.outRdy, dlt: dlt};

   rhReadReturn rhReadReturn_i (
      .clk     (clk),
      .rst     (rst),
      .strobes (strobes),
      .dbWord  (dbWord),
      .cs1Word (cs1Word),
      .status  (bufStatus),
      .devOut  (devOut)
   );

endmodule

/* design/rhDataBuffer.sv */
/*
 * RH11 data buffer
 * Circular FIFO of 16-bit words between the bus and the drive.
 * A DB write pushes, a DB read pops the oldest word. Overrun and
 * underrun are dropped and reported as a data late event. The word
 * at the read pointer is registered every clock for the read path.
 */
module rhDataBuffer #(
   parameter int bufDepth = 66              // Words held
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                bufClear,
   input  logic                dbWrite,
   input  logic                dbRead,
   input  rhRegPkg::regWordT   dbData,
   output rhRegPkg::regWordT   dbWord,
   output rhRegPkg::bufStatusT status,
   output logic                dltEvent
);

   import rhRegPkg::*;

   localparam int ptrWidth = $clog2(bufDepth);
   localparam int cntWidth = $clog2(bufDepth + 1);

   typedef logic [ptrWidth-1:0] bufPtrT;    // Memory index
   typedef logic [cntWidth-1:0] bufCntT;    // 0 to bufDepth inclusive

   localparam bufPtrT lastPtr   = bufPtrT'(bufDepth - 1);
   localparam bufCntT fullCount = bufCntT'(bufDepth);

   regWordT mem [bufDepth];                 // Dual port storage
   bufPtrT  rdPtr;
   bufPtrT  wrPtr;
   bufCntT  depth;                          // Words currently held
   logic    full;
   logic    empty;
   logic    doPush;
   logic    doPop;

   // Pointer step, wraps at the last word rather than at a power of two
   function automatic bufPtrT nextPtr(input bufPtrT ptr);
      if (ptr == lastPtr)
         return '0;
      return ptr + 1'b1;
   endfunction

   assign full   = (depth == fullCount);
   assign empty  = (depth == '0);
   assign doPush = dbWrite & ~full;         // Dropped when full
   assign doPop  = dbRead & ~empty;         // Dropped when empty

   ////////////////////////////////////////////////////////////
   // Pointers and depth
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst || bufClear)                  // Clear beats push and pop
      begin
         rdPtr <= '0;
         wrPtr <= '0;
         depth <= '0;
      end
      else
      begin
         if (doPush)
            wrPtr <= nextPtr(wrPtr);
         if (doPop)
            rdPtr <= nextPtr(rdPtr);
         if (doPush && !doPop)
            depth <= depth + 1'b1;
         else if (doPop && !doPush)
            depth <= depth - 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Storage and output word
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (doPush && !bufClear)
         mem[wrPtr] <= dbData;
      dbWord <= mem[rdPtr];                 // Oldest word, one clock behind
   end

   // Overrun or underrun, latched in CS2 as DLT
   assign dltEvent = (dbWrite & full) | (dbRead & empty);

   assign status.ir     = ~full;
   assign status.outRdy = ~empty;
   assign status.dlt    = 1'b0;             // Latch lives in the CS block

endmodule

/* design/rhReadReturn.sv */
/*
 * RH11 read return stage
 * Acknowledges every decoded operation one clock after the update
 * stage and returns the selected register word on reads.
 */
module rhReadReturn (
   input  logic                clk,
   input  logic                rst,
   input  rhRegPkg::regStrobeT strobes,
   input  rhRegPkg::regWordT   dbWord,
   input  rhRegPkg::regWordT   cs1Word,
   input  rhRegPkg::bufStatusT status,
   output rhBusPkg::devReplyT  devOut
);

   import rhBusPkg::*;
   import rhRegPkg::*;

   regWordT cs2Word;                        // Assembled status view
   regWordT readWord;                       // Zero unless a read
   logic    anyStrobe;
   logic    ackReg;
   devDataT dataReg;

   always_comb
   begin
      cs2Word         = '0;
      cs2Word[cs2Ir]  = status.ir;
      cs2Word[cs2Or]  = status.outRdy;
      cs2Word[cs2Dlt] = status.dlt;         // Value before this read's update
   end

   always_comb
   begin
      readWord = '0;
      if (strobes.cs1Read)
         readWord = cs1Word;
      else if (strobes.cs2Read)
         readWord = cs2Word;
      else if (strobes.dbRead)
         readWord = dbWord;                 // Word about to be popped
   end

   assign anyStrobe = strobes.cs1Write | strobes.cs2Write | strobes.dbWrite |
                      strobes.cs1Read  | strobes.cs2Read  | strobes.dbRead;

   always_ff @(posedge clk)
   begin
      if (rst)
         ackReg <= 1'b0;
      else
         ackReg <= anyStrobe;               // Single cycle, strobes are pulses
   end

   always_ff @(posedge clk)
   begin
      dataReg <= devDataT'(readWord);       // Zero extended to 36 bits
   end

   assign devOut = '{ack: ackReg, data: dataReg};

endmodule

/* design/rhRegDecode.sv */
/*
 * RH11 register decode stage
 * Captures one device bus cycle and turns it into a single
 * per-register pulse one clock later. The bus word is cut
 * down to the 16-bit register width here, once.
 */
module rhRegDecode (
   input  logic                clk,
   input  logic                rst,
   input  rhBusPkg::devCycleT  devIn,
   output rhRegPkg::regStrobeT strobes
);

   import rhBusPkg::*;
   import rhRegPkg::*;

   devCycleT  cycleReg;                     // Sampled bus cycle
   regStrobeT strobeNext;                   // Decoded pulses, not yet registered
   logic      isWrite;
   logic      isRead;

   ////////////////////////////////////////////////////////////
   // Bus sample
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cycleReg.read  <= 1'b0;
         cycleReg.write <= 1'b0;
      end
      else
      begin
         cycleReg <= devIn;
      end
   end

   ////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////

   // Write wins if a cycle shows both strobes
   assign isWrite = cycleReg.write;
   assign isRead  = cycleReg.read & ~cycleReg.write;

   always_comb
   begin
      strobeNext          = '0;
      strobeNext.cs1Write = isWrite && (cycleReg.addr == addrCs1);
      strobeNext.cs2Write = isWrite && (cycleReg.addr == addrCs2);
      strobeNext.dbWrite  = isWrite && (cycleReg.addr == addrDb);
      strobeNext.cs1Read  = isRead  && (cycleReg.addr == addrCs1);
      strobeNext.cs2Read  = isRead  && (cycleReg.addr == addrCs2);
      strobeNext.dbRead   = isRead  && (cycleReg.addr == addrDb);
      strobeNext.data     = regWordT'(cycleReg.data); // Drop bits 35:16
   end

   // Second register, pulses seen by the update stage
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         strobes <= '0;
      end
      else
      begin
         strobes <= strobeNext;
      end
   end

endmodule

/* design/rhRegPkg.sv */
/*
 * RH11 register package
 * Register word type, bit positions inside CS1 and CS2, and the
 * structs passed between the controller pipeline stages.
 */
package rhRegPkg;

   typedef logic [15:0] regWordT;           // Unibus sized register word

   ////////////////////////////////////////////////////////////
   // CS1 bits
   ////////////////////////////////////////////////////////////

   localparam int cs1Go  = 0;               // Start function
   localparam int cs1Tre = 14;              // Transfer error clear

   // Function field, bits 5 to 1, as a mask
   localparam regWordT cs1Func = 16'h003e;

   ////////////////////////////////////////////////////////////
   // CS2 bits
   ////////////////////////////////////////////////////////////

   localparam int cs2Clr = 5;               // Controller clear
   localparam int cs2Ir  = 6;               // Input ready
   localparam int cs2Or  = 7;               // Output ready
   localparam int cs2Dlt = 15;              // Data late

   ////////////////////////////////////////////////////////////
   // Stage structs
   ////////////////////////////////////////////////////////////

   // Decoded pulses out of the first stage, at most one set per op
   typedef struct packed {
      logic    cs1Write;
      logic    cs2Write;
      logic    dbWrite;
      logic    cs1Read;
      logic    cs2Read;
      logic    dbRead;
      regWordT data;                        // Low half of the bus word
   } regStrobeT;

   // Data buffer state as reported in CS2
   typedef struct packed {
      logic ir;                             // Room for another word
      logic outRdy;                         // At least one word held
      logic dlt;                            // Data late latch
   } bufStatusT;

endpackage

/* list.f */
design/rhBusPkg.sv
design/rhRegPkg.sv
design/rhRegDecode.sv
design/rhDataBuffer.sv
design/rhControlStatus.sv
design/rhReadReturn.sv
design/rhController.sv
test/rhDataBufferProperties.sv
test/rhControllerTb.sv

/* test/rhControllerTb.sv */
/*
 * RH11 controller slice testbench
 * LFSR driven register traffic on the device bus, checked against
 * a FIFO, DLT and CS1 model kept here.
 */
module rhControllerTb;

   import rhBusPkg::*;

   localparam int depthUnderTest = 66;
   localparam int opTotal        = 2000;
   localparam int ackTimeout     = 10;      // Cycles
   localparam int fillMode       = 0;
   localparam int drainMode      = 1;
   localparam int mixedMode      = 2;

   logic        clk;
   logic        rst;
   logic        devReset;
   devCycleT    devIn;
   devReplyT    devOut;
   logic [31:0] lfsrState;
   logic [15:0] fifoModel [$];              // Expected buffer contents
   logic        dltModel;
   logic [15:0] cs1Model;                   // Function bits only

   rhController #(
      .bufDepth (depthUnderTest)
   ) rhController_i (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .devIn    (devIn),
      .devOut   (devOut)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Random source and reporting
   ////////////////////////////////////////////////////////////

   // Taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] randBits(input int count);
      logic [31:0] value;
      logic        feedback;
      value = '0;
      for (int i = 0; i < count; i++)
      begin
         feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
         lfsrState = {lfsrState[30:0], feedback};
         value     = {value[30:0], feedback};
      end
      return value;
   endfunction

   function automatic devDataT randWord();
      logic [31:0] highBits;
      logic [31:0] lowBits;
      highBits = randBits(4);
      lowBits  = randBits(32);
      return {highBits[3:0], lowBits};
   endfunction

   task automatic stopRun();
      $display("Checks failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic checkWord(input string what, input devDataT got, input devDataT exp);
      assert (got === exp)
      else
      begin
         $display("[ERROR] %0t: %s returned 0x%09h, expected 0x%09h", $time, what, got, exp);
         stopRun();
      end
   endtask

   // Quiet cycles where ack must stay low
   task automatic idleCycles(input int count);
      repeat (count)
      begin
         @(negedge clk);
         assert (!devOut.ack)
         else
         begin
            $display("Unexpected extra acknowledge at time %0t", $time);
            stopRun();
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Bus operations
   ////////////////////////////////////////////////////////////

   task automatic busOp(input devAddrT addr, input logic isRead, input devDataT wdata,
                        output devDataT rdata);
      logic seen;
      int   waited;
      @(posedge clk);
      devIn <= '{addr: addr, read: isRead, write: !isRead, data: wdata};
      @(posedge clk);
      devIn.read  <= 1'b0;                  // Single cycle strobe
      devIn.write <= 1'b0;
      seen   = 1'b0;
      waited = 0;
      rdata  = '0;
      while (!seen && waited < ackTimeout)
      begin
         @(negedge clk);                    // Reply stable mid cycle
         waited++;
         if (devOut.ack)
         begin
            seen  = 1'b1;
            rdata = devOut.data;
         end
      end
      assert (seen)
      else
      begin
         $display("No acknowledge within %0d cycles at time %0t", ackTimeout, $time);
         stopRun();
      end
   endtask

   task automatic dbWriteOp();
      devDataT wdata;
      devDataT rdata;
      wdata = randWord();
      busOp(addrDb, 1'b0, wdata, rdata);
      checkWord("DB write reply", rdata, '0);
      if (fifoModel.size() == depthUnderTest)
         dltModel = 1'b1;                   // Overrun drops the word
      else
         fifoModel.push_back(wdata[15:0]);
   endtask

   task automatic dbReadOp();
      devDataT rdata;
      logic [15:0] expWord;
      busOp(addrDb, 1'b1, '0, rdata);
      if (fifoModel.size() == 0)
         dltModel = 1'b1;                   // Underrun leaves data undefined
      else
      begin
         expWord = fifoModel.pop_front();
         checkWord("DB read", rdata, devDataT'(expWord));
      end
   endtask

   task automatic cs2ReadOp();
      devDataT rdata;
      devDataT expWord;
      expWord     = '0;
      expWord[6]  = (fifoModel.size() != depthUnderTest); // IR
      expWord[7]  = (fifoModel.size() != 0);              // OR
      expWord[15] = dltModel;
      busOp(addrCs2, 1'b1, '0, rdata);
      checkWord("CS2 read", rdata, expWord);
   endtask

   task automatic cs1ReadOp();
      devDataT rdata;
      busOp(addrCs1, 1'b1, '0, rdata);
      checkWord("CS1 read", rdata, devDataT'(cs1Model));
   endtask

   task automatic cs1WriteOp();
      devDataT wdata;
      devDataT rdata;
      logic    go;
      logic    tre;
      wdata     = randWord();
      go        = (randBits(2) == 0);      // Keep clears rare
      tre       = (randBits(2) == 0);
      wdata[0]  = go;
      wdata[14] = tre;
      busOp(addrCs1, 1'b0, wdata, rdata);
      checkWord("CS1 write reply", rdata, '0);
      cs1Model = wdata[15:0] & 16'h003e;   // Function field 5:1
      if (go || tre)
         fifoModel.delete();
      if (tre)
         dltModel = 1'b0;
   endtask

   task automatic cs2WriteOp();
      devDataT wdata;
      devDataT rdata;
      wdata    = randWord();
      wdata[5] = (randBits(2) == 0);       // CLR
      busOp(addrCs2, 1'b0, wdata, rdata);
      checkWord("CS2 write reply", rdata, '0);
      if (wdata[5])
      begin
         fifoModel.delete();
         dltModel = 1'b0;
      end
   endtask

   // Level pulse with no ack expected
   task automatic devResetOp();
      @(posedge clk);
      devReset <= 1'b1;
      @(posedge clk);
      devReset <= 1'b0;
      fifoModel.delete();
      dltModel = 1'b0;
   endtask

   task automatic controlOp();
      logic [31:0] sel;
      sel = randBits(3);
      case (sel)
         2:       cs1ReadOp();
         3:       cs1WriteOp();
         4:       cs2WriteOp();
         5:       devResetOp();
         default: cs2ReadOp();
      endcase
   endtask

   // Fill and drain phases push the buffer to full and to empty
   task automatic runRandomOp(input int mode);
      logic [31:0] sel;
      sel = randBits(5);
      if (mode == mixedMode)
      begin
         if (sel < 12)
            dbWriteOp();
         else if (sel < 24)
            dbReadOp();
         else
            controlOp();
      end
      else if (sel < 28)
      begin
         if (mode == drainMode)
            dbReadOp();
         else
            dbWriteOp();
      end
      else if (sel < 31)
      begin
         if (mode == drainMode)
            dbWriteOp();
         else
            dbReadOp();
      end
      else
         controlOp();
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      lfsrState = 32'hc790_0059;
      rst       = 1'b1;
      devReset  = 1'b0;
      devIn     = '0;
      dltModel  = 1'b0;
      cs1Model  = '0;
      fifoModel.delete();
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      idleCycles(2);
      for (int op = 0; op < opTotal; op++)
      begin
         runRandomOp((op / 150) % 3);      // Phase changes every 150 ops
         idleCycles(3 + randBits(2));      // Gap of 3 to 6 cycles
      end
      if (rhController_i.rhDataBuffer_i.rhDataBufferProperties_i.violations == 0)
      begin
         $display("All checks passed");
         $finish;
      end
      else
      begin
         $display("Data buffer assertions failed during the run");
         stopRun();
      end
   end

endmodule

/* test/rhDataBufferProperties.sv */
/*
 * RH11 data buffer properties
 * Concurrent checks on depth bounds, status flags and clear,
 * bound into every rhDataBuffer instance.
 */
module rhDataBufferProperties #(
   parameter int bufDepth = 66              // Must match the buffer
) (
   input logic                            clk,
   input logic                            rst,
   input logic                            bufClear,
   input logic [$clog2(bufDepth + 1)-1:0] depth,
   input rhRegPkg::bufStatusT             status
);

   int violations = 0;                      // Read by the testbench at the end

   // Count never runs past the memory size
   depthBound: assert property (@(posedge clk) disable iff (rst) depth <= bufDepth)
      else
      begin
         violations++;
         $error("Buffer depth above bufDepth");
      end

   // Full and empty at once would mean a broken count
   flagsSane: assert property (@(posedge clk) disable iff (rst) status.ir || status.outRdy)
      else
      begin
         violations++;
         $error("Input ready and output ready both low");
      end

   clearEmpties: assert property (@(posedge clk) disable iff (rst) bufClear |=> depth == '0)
      else
      begin
         violations++;
         $error("Buffer not empty one cycle after clear");
      end

endmodule

bind rhDataBuffer rhDataBufferProperties #(
   .bufDepth (bufDepth)
) rhDataBufferProperties_i (
   .clk      (clk),
   .rst      (rst),
   .bufClear (bufClear),
   .depth    (depth),
   .status   (status)
);
